// ==== common/kw_addr_pkg.sv ====
/*
  Address side definitions for the kernel weight address generator.
  Holds the ROM address and feature size types, and the functions
  that give the first and last weight ROM address of the segment
  that belongs to a feature size N. The bounds table in the RTL is
  built from these functions at elaboration.
*/

package kw_addr_pkg;

  localparam int unsigned ADDR_W   = 23;
  localparam int unsigned FEAT_W   = 8;
  localparam int unsigned FEAT_NUM = 2 ** FEAT_W;
  localparam int unsigned MIN_FEAT = 6;

  typedef logic [ADDR_W-1:0] rom_addr_t;
  typedef logic [FEAT_W-1:0] feat_size_t;

  // First address of the segment for feature size n
  function automatic rom_addr_t seg_start(feat_size_t n);
    int unsigned m;
    int unsigned sum_sq;
    if (n <= MIN_FEAT)
    begin
      return rom_addr_t'(1);
    end
    // Sum of k squared for k = 1 .. n-6
    m = n - MIN_FEAT;
    sum_sq = m * (m + 1) * (2 * m + 1) / 6;
    return rom_addr_t'(sum_sq);
  endfunction

  // Last address, start plus (n-5)^2 minus one
  function automatic rom_addr_t seg_last(feat_size_t n);
    int unsigned side;
    if (n < MIN_FEAT)
    begin
      // End below start marks an empty segment
      return rom_addr_t'(0);
    end
    side = n - (MIN_FEAT - 1);
    return seg_start(n) + rom_addr_t'(side * side) - rom_addr_t'(1);
  endfunction

endpackage

// ==== common/kw_ctrl_pkg.sv ====
/*
  Control side definitions for the kernel weight address generator.
  Settle delay between a start and the first ROM address, the width
  of its counter, and the state encoding of the address sequencer.
*/

package kw_ctrl_pkg;

  // Cycles spent settling after a run starts
  localparam int unsigned SETTLE_CYCLES = 8;
  localparam int unsigned SETTLE_W      = 3;

  // Sequencer states
  typedef enum logic [1:0] {
    IDLE,
    SETTLE,
    STREAM,
    DONE
  } seq_state_t;

endpackage

// ==== hw/addr_seq/kw_conv_req_port.sv ====
/*
  Four-phase request/acknowledge port of the address generator.
  Accepts a request while idle, latches the feature size for the
  whole run and pulses run_start one cycle later. Raises conv_ack on
  run_done and drops it once conv_req has fallen.
*/

`timescale 1ns/1ps

module kw_conv_req_port (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    conv_req,
  input  kw_addr_pkg::feat_size_t feat_size,
  input  logic                    run_done,
  output logic                    conv_ack,
  output logic                    run_start,
  output kw_addr_pkg::feat_size_t run_feat
);

  import kw_addr_pkg::*;

  typedef enum logic [1:0] {
    ST_WAIT,
    ST_BUSY,
    ST_ACK
  } port_state_t;

  port_state_t state;
  logic        accept;

  // Requests seen while busy or acknowledging are ignored
  assign accept = (state == ST_WAIT) && conv_req;

  assign conv_ack = (state == ST_ACK);

  //////////////////////////////////////////////////
  // Handshake FSM
  //////////////////////////////////////////////////

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      state     <= ST_WAIT;
      run_start <= 1'b0;
    end
    else
    begin
      run_start <= accept;
      case (state)
        ST_WAIT:
          if (accept)
            state <= ST_BUSY;
        ST_BUSY:
          if (run_done)
            state <= ST_ACK;
        ST_ACK:
          // Hold the ack until the controller lets go
          if (!conv_req)
            state <= ST_WAIT;
        default:
          state <= ST_WAIT;
      endcase
    end
  end

  // Feature size stays fixed for the run
  always_ff @(posedge clk)
  begin
    if (accept)
      run_feat <= feat_size;
  end

endmodule

// ==== hw/addr_seq/kw_segment_bounds.sv ====
/*
  Segment bounds lookup for the weight ROM.
  Two constant tables, filled at elaboration from the package
  functions, give the first and last address for every feature size.
  Sizes without a segment read start 1 and end 0, so the end lies
  below the start. Purely combinational.
*/

`timescale 1ns/1ps

module kw_segment_bounds (
  input  kw_addr_pkg::feat_size_t run_feat,
  output kw_addr_pkg::rom_addr_t  seg_first,
  output kw_addr_pkg::rom_addr_t  seg_end
);

  import kw_addr_pkg::*;

  rom_addr_t start_tbl [FEAT_NUM];
  rom_addr_t end_tbl   [FEAT_NUM];

  //////////////////////////////////////////////////
  // Tables, one entry per feature size
  //////////////////////////////////////////////////

  for (genvar i = 0; i < FEAT_NUM; i++)
  begin : g_bounds
    assign start_tbl[i] = seg_start(feat_size_t'(i));
    assign end_tbl[i]   = seg_last(feat_size_t'(i));
  end

  // Read by the held feature size of the current run
  assign seg_first = start_tbl[run_feat];
  assign seg_end   = end_tbl[run_feat];

endmodule

// ==== hw/addr_seq/kw_addr_sequencer.sv ====
/*
  Weight ROM address sequencer.
  On run_start it waits the settle delay, loads the segment start and
  counts up by one per clock until the segment end, with addr_valid
  high for every address. run_done pulses in the cycle after the last
  address. An empty segment goes straight to done with no valid
  address. The address holds its value between runs.
*/

`timescale 1ns/1ps

module kw_addr_sequencer (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   run_start,
  input  kw_addr_pkg::rom_addr_t seg_first,
  input  kw_addr_pkg::rom_addr_t seg_end,
  output kw_addr_pkg::rom_addr_t rom_addr,
  output logic                   addr_valid,
  output logic                   run_done
);

  import kw_addr_pkg::*;
  import kw_ctrl_pkg::*;

  seq_state_t          state;
  logic [SETTLE_W-1:0] settle_cnt;
  logic                settle_last;
  logic                seg_empty;
  logic                at_end;

  assign settle_last = (settle_cnt == SETTLE_W'(SETTLE_CYCLES - 1));
  assign seg_empty   = (seg_end < seg_first);
  assign at_end      = (rom_addr == seg_end);

  // DONE lasts one cycle
  assign run_done = (state == DONE);

  //////////////////////////////////////////////////
  // Sequencer FSM
  //////////////////////////////////////////////////

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      state <= IDLE;
    end
    else
    begin
      case (state)
        IDLE:
          if (run_start)
            state <= SETTLE;
        SETTLE:
          if (settle_last)
            state <= seg_empty ? DONE : STREAM;
        STREAM:
          if (at_end)
            state <= DONE;
        DONE:
          state <= IDLE;
        default:
          state <= IDLE;
      endcase
    end
  end

  // Settle delay counter
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      settle_cnt <= '0;
    else if (state == SETTLE)
      settle_cnt <= settle_cnt + 1'b1;
    else
      settle_cnt <= '0;
  end

  //////////////////////////////////////////////////
  // Address counter and valid flag
  //////////////////////////////////////////////////

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      rom_addr   <= '0;
      addr_valid <= 1'b0;
    end
    else if (state == SETTLE && settle_last && !seg_empty)
    begin
      rom_addr   <= seg_first;
      addr_valid <= 1'b1;
    end
    else if (state == STREAM)
    begin
      if (at_end)
      begin
        // Last address stays on the bus
        addr_valid <= 1'b0;
      end
      else
      begin
        rom_addr <= rom_addr + rom_addr_t'(1);
      end
    end
  end

endmodule

// ==== hw/kw_addr_gen_top.sv ====
/*
  Kernel weight address generator, top level.
  A controller requests a run with conv_req and a feature size. After
  the settle delay the block streams the weight ROM segment of that
  size, one address per clock with addr_valid, then raises conv_ack.
  The controller drops conv_req to finish the handshake.
*/

`timescale 1ns/1ps

module kw_addr_gen_top (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    conv_req,
  input  kw_addr_pkg::feat_size_t feat_size,
  output logic                    conv_ack,
  output kw_addr_pkg::rom_addr_t  rom_addr,
  output logic                    addr_valid
);

  import kw_addr_pkg::*;

  logic       run_start;
  logic       run_done;
  feat_size_t run_feat;
  rom_addr_t  seg_first;
  rom_addr_t  seg_end;

  kw_conv_req_port u_req_port (
    .clk       (clk),
    .reset     (reset),
    .conv_req  (conv_req),
    .feat_size (feat_size),
    .run_done  (run_done),
    .conv_ack  (conv_ack),
    .run_start (run_start),
    .run_feat  (run_feat)
  );

  kw_segment_bounds u_bounds (
    .run_feat  (run_feat),
    .seg_first (seg_first),
    .seg_end   (seg_end)
  );

  kw_addr_sequencer u_sequencer (
    .clk        (clk),
    .reset      (reset),
    .run_start  (run_start),
    .seg_first  (seg_first),
    .seg_end    (seg_end),
    .rom_addr   (rom_addr),
    .addr_valid (addr_valid),
    .run_done   (run_done)
  );

endmodule

// ==== verification/kw_tb_model.svh ====
/*
  Reference model and helpers for the address generator testbench.
  Included inside the testbench top module. The model derives each
  segment from the sum-of-squares rule, and the wait tasks poll the
  DUT ack on the falling edge with a cycle limit.
*/

`ifndef KW_TB_MODEL_SVH
`define KW_TB_MODEL_SVH

// Segment start, summed term by term
function automatic int unsigned model_first(int unsigned n);
  int unsigned sum;
  sum = 0;
  if (n < 7)
  begin
    return 1;
  end
  for (int unsigned k = 1; k <= n - 6; k++)
  begin
    sum += k * k;
  end
  return sum;
endfunction

// Number of addresses, zero below size 6
function automatic int unsigned model_count(int unsigned n);
  if (n < 6)
  begin
    return 0;
  end
  return (n - 5) * (n - 5);
endfunction

task automatic stop_on_error(input string why);
  $display("%s", why);
  $display("FAIL: see errors above");
  $fatal(1);
endtask

task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
  if (got !== exp)
  begin
    stop_on_error($sformatf("FAIL %s got 0x%0h expected 0x%0h", name, got, exp));
  end
endtask

task automatic wait_ack_high(input int unsigned limit);
  int unsigned n;
  n = 0;
  while (!conv_ack)
  begin
    @(negedge clk);
    n++;
    if (n > limit)
      stop_on_error($sformatf("Timeout: conv_ack never rose within %0d cycles", limit));
  end
endtask

task automatic wait_ack_low(input int unsigned limit);
  int unsigned n;
  n = 0;
  while (conv_ack)
  begin
    @(negedge clk);
    n++;
    if (n > limit)
      stop_on_error($sformatf("Timeout: conv_ack did not fall within %0d cycles", limit));
  end
endtask

`endif

// ==== verification/tb_kw_addr_gen.sv ====
/*
  Testbench for the kernel weight address generator.
  Drives four-phase requests on the falling edge, collects every
  valid ROM address and compares the stream with the model. Covers
  reset, small and random sizes, empty segments and size 255.
*/

`timescale 1ns/1ps

module tb_kw_addr_gen;

  import kw_addr_pkg::*;

  logic        clk;
  logic        reset;
  logic        conv_req;
  feat_size_t  feat_size;
  logic        conv_ack;
  rom_addr_t   rom_addr;
  logic        addr_valid;

  integer      seed;
  int unsigned cyc;
  int unsigned req_cyc;
  int unsigned first_cyc;
  int unsigned addr_seen[$];

  `include "kw_tb_model.svh"

  kw_addr_gen_top dut0 (
    .clk        (clk),
    .reset      (reset),
    .conv_req   (conv_req),
    .feat_size  (feat_size),
    .conv_ack   (conv_ack),
    .rom_addr   (rom_addr),
    .addr_valid (addr_valid)
  );

  always #2 clk = ~clk;

  always @(posedge clk)
    cyc <= cyc + 1;

  // Monitor, outputs are stable on the falling edge
  always @(negedge clk)
  begin
    if (addr_valid)
    begin
      if (addr_seen.size() == 0)
        first_cyc = cyc;
      addr_seen.push_back(rom_addr);
    end
  end

  // One full handshake for size n
  task automatic run_one(input int unsigned n, input bit swap_feat);
    int unsigned first;
    int unsigned count;
    int unsigned last;
    first = model_first(n);
    count = model_count(n);
    last  = first + count - 1;
    addr_seen.delete();
    feat_size = feat_size_t'(n);
    conv_req  = 1'b1;
    req_cyc   = cyc;
    @(negedge clk);
    // Size change mid-run must not reach the segment
    if (swap_feat)
      feat_size = feat_size_t'($random(seed));
    wait_ack_high(count + 40);
    check("addr_count", addr_seen.size(), count);
    if (count > 0)
    begin
      check("first_cycle", first_cyc - req_cyc, 10);
      for (int unsigned i = 0; i < count; i++)
        check("rom_addr", addr_seen[i], first + i);
      check("rom_addr", rom_addr, last);
    end
    repeat (3)
    begin
      @(negedge clk);
      check("conv_ack", conv_ack, 1);
    end
    conv_req = 1'b0;
    wait_ack_low(4);
    if (count > 0)
      check("rom_addr", rom_addr, last);
  endtask

  initial
  begin
    clk       = 1'b0;
    reset     = 1'b1;
    conv_req  = 1'b0;
    feat_size = '0;
    seed      = 32'h1830;
    cyc       = 0;

    repeat (16)
    begin
      @(negedge clk);
      check("conv_ack", conv_ack, 0);
      check("addr_valid", addr_valid, 0);
      check("rom_addr", rom_addr, 0);
    end
    reset = 1'b0;
    @(negedge clk);
    check("conv_ack", conv_ack, 0);
    check("addr_valid", addr_valid, 0);
    check("rom_addr", rom_addr, 0);

    for (int unsigned n = 6; n <= 9; n++)
    begin
      run_one(n, 1'b0);
      if (n == 8)
      begin
        check("rom_addr", addr_seen[0], 5);
        check("rom_addr", rom_addr, 13);
      end
    end

    repeat (20)
      run_one(6 + ($unsigned($random(seed)) % 35), 1'b1);

    for (int unsigned n = 0; n < 6; n++)
      run_one(n, 1'b1);

    // Full 23-bit range
    run_one(255, 1'b0);
    check("rom_addr", addr_seen[0], 32'd5177125);
    check("rom_addr", rom_addr, 32'd5239624);

    $display("PASS: all tests");
    $finish;
  end

endmodule

// ==== sources.f ====
+incdir+verification
common/kw_addr_pkg.sv
common/kw_ctrl_pkg.sv
hw/addr_seq/kw_conv_req_port.sv
hw/addr_seq/kw_segment_bounds.sv
hw/addr_seq/kw_addr_sequencer.sv
hw/kw_addr_gen_top.sv
verification/tb_kw_addr_gen.sv

// ==== Bender.yml ====
package:
  name: kw_addr_gen

sources:
  # Packages first, then the RTL from the leaves up
  - files:
      - common/kw_addr_pkg.sv
      - common/kw_ctrl_pkg.sv
      - hw/addr_seq/kw_conv_req_port.sv
      - hw/addr_seq/kw_segment_bounds.sv
      - hw/addr_seq/kw_addr_sequencer.sv
      - hw/kw_addr_gen_top.sv

  # Testbench
  - target: test
    include_dirs:
      - verification
    files:
      - verification/tb_kw_addr_gen.sv
